//--- wormhole_concentrator.f
src/wormhole_pkg.sv
src/wormhole_in_channel.sv
src/wormhole_output_control.sv
src/wormhole_concentrator_in.sv
tests/wormhole_clock_gen.sv
tests/wormhole_concentrator_chk.sv
tests/wormhole_concentrator_tb.sv

//--- Bender.yml
package:
  name: wormhole_concentrator

sources:
  - src/wormhole_pkg.sv
  - src/wormhole_in_channel.sv
  - src/wormhole_output_control.sv
  - src/wormhole_concentrator_in.sv
  - target: test
    files:
      - tests/wormhole_clock_gen.sv
      - tests/wormhole_concentrator_chk.sv
      - tests/wormhole_concentrator_tb.sv

//--- tests/wormhole_concentrator_tb.sv
module wormhole_concentrator_tb;

  localparam int PKTS    = 12;
  localparam int TIMEOUT = 2000;

  logic                                           clk;
  logic                                           reset;
  logic                [wormhole_pkg::NUM_IN-1:0] link_v;
  wormhole_pkg::flit_t [wormhole_pkg::NUM_IN-1:0] link_data;
  logic                [wormhole_pkg::NUM_IN-1:0] link_ready;
  logic                                           conc_v;
  wormhole_pkg::flit_t                            conc_data;
  logic                                           conc_ready;

  // random source and per link stimulus state
  logic [15:0]                     lfsr_r = 16'd46713;
  logic [wormhole_pkg::NUM_IN-1:0] acc_r  = '0;
  int                              body_left [wormhole_pkg::NUM_IN];
  int                              gap_left  [wormhole_pkg::NUM_IN];
  int                              started   [wormhole_pkg::NUM_IN];
  int                              finished;

  // reference model, accepted flits queued per link
  wormhole_pkg::flit_t exp_q [wormhole_pkg::NUM_IN][$];
  int                  delivered [wormhole_pkg::NUM_IN];
  int                  queued;
  int                  out_left;
  int                  out_link;
  int                  cycles;

  wormhole_clock_gen i_clock_gen
  (
    .clk_o   (clk),
    .reset_o (reset)
  );

  wormhole_concentrator_in i_wormhole_concentrator_in
  (
    .clk_i        (clk),
    .reset_i      (reset),
    .link_v_i     (link_v),
    .link_data_i  (link_data),
    .link_ready_o (link_ready),
    .conc_v_o     (conc_v),
    .conc_data_o  (conc_data),
    .conc_ready_i (conc_ready)
  );

  // protocol assertions, yumi is internal to the top level
  bind wormhole_concentrator_in wormhole_concentrator_chk i_chk
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .conc_v_i     (conc_v_o),
    .conc_data_i  (conc_data_o),
    .conc_ready_i (conc_ready_i),
    .yumi_i       (yumi)
  );

  // galois lfsr, one step per bit taken
  function automatic int unsigned take_bits(input int n);
    int unsigned bits;
    bits = 0;
    for (int k = 0; k < n; k++)
    begin
      bits   = {bits[30:0], lfsr_r[0]};
      lfsr_r = (lfsr_r >> 1) ^ (lfsr_r[0] ? 16'hB400 : 16'h0000);
    end
    return bits;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flit(input string name, input wormhole_pkg::flit_t got,
                            input wormhole_pkg::flit_t want);
    if (got !== want)
    begin
      report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_len(input string name, input wormhole_pkg::len_t got,
                           input wormhole_pkg::len_t want);
    if (got !== want)
    begin
      report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    if (got != want)
    begin
      report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      report_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  // nothing presented, every buffer free
  task automatic check_idle();
    check_bit("conc_v_o", conc_v, 1'b0);
    for (int n = 0; n < wormhole_pkg::NUM_IN; n++)
    begin
      check_bit($sformatf("link_ready_o[%0d]", n), link_ready[n], 1'b1);
    end
  endtask

  task automatic watch_timeout(input string what);
    cycles++;
    if (cycles > TIMEOUT)
    begin
      report_error($sformatf("gave up after %0d cycles waiting for %s", TIMEOUT, what));
    end
  endtask

  // called on the falling edge, a held flit stays until the link takes it
  task automatic drive_inputs();
    wormhole_pkg::flit_t hdr;
    for (int n = 0; n < wormhole_pkg::NUM_IN; n++)
    begin
      if (!link_v[n] || acc_r[n])
      begin
        link_v[n] = 1'b0;
        if (gap_left[n] > 0)
        begin
          gap_left[n]--;
        end
        else if (body_left[n] > 0)
        begin
          link_data[n] = wormhole_pkg::flit_t'(take_bits(16));
          link_v[n]    = 1'b1;
          body_left[n]--;
        end
        else if (started[n] < PKTS)
        begin
          // random cord and payload, random len, cid is the link index
          hdr = wormhole_pkg::flit_t'(take_bits(16));
          hdr[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH] =
            wormhole_pkg::len_t'(take_bits(3));
          hdr[wormhole_pkg::CID_LSB +: wormhole_pkg::CID_WIDTH] =
            (wormhole_pkg::CID_WIDTH)'(n);
          link_data[n] = hdr;
          link_v[n]    = 1'b1;
          body_left[n] = int'(hdr[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH]);
          started[n]++;
        end
        // last flit of a packet driven, idle 0 to 3 cycles after it
        if (link_v[n] && body_left[n] == 0)
        begin
          gap_left[n] = int'(take_bits(2));
          finished++;
        end
      end
    end
    // output back-pressure about one cycle in four
    conc_ready = (take_bits(2) != 0);
  endtask

  // header picks the queue by cid, its body must drain that same queue
  task automatic check_output(input wormhole_pkg::flit_t got);
    wormhole_pkg::flit_t want;
    logic                is_hdr;
    is_hdr = (out_left == 0);
    if (is_hdr)
    begin
      out_link = int'(got[wormhole_pkg::CID_LSB +: wormhole_pkg::CID_WIDTH]);
      out_left = int'(got[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH]);
    end
    else
    begin
      out_left--;
    end
    if (exp_q[out_link].size() == 0)
    begin
      report_error($sformatf("flit for link %0d came out but none was pending", out_link));
    end
    else
    begin
      want = exp_q[out_link].pop_front();
      queued--;
      // a wrong length field is named before the whole word
      if (is_hdr)
      begin
        check_len("conc_data_o len field",
                  got[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH],
                  want[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH]);
      end
      check_flit("conc_data_o", got, want);
      if (out_left == 0)
      begin
        delivered[out_link]++;
      end
    end
  endtask

  // transfers seen on the rising edge, before any register moves
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (conc_v && conc_ready)
      begin
        check_output(conc_data);
      end
      acc_r = link_v & link_ready;
      for (int n = 0; n < wormhole_pkg::NUM_IN; n++)
      begin
        if (acc_r[n])
        begin
          exp_q[n].push_back(link_data[n]);
          queued++;
        end
      end
    end
  end

  initial
  begin
    link_v     = '0;
    link_data  = '0;
    conc_ready = 1'b1;
    // outputs during reset, the first edge only clears unknowns
    cycles = 0;
    do
    begin
      @(posedge clk);
      if (cycles > 0)
      begin
        check_idle();
      end
      watch_timeout("reset release");
    end
    while (reset);
    @(negedge clk);
    check_idle();

    cycles = 0;
    drive_inputs();
    while (finished < wormhole_pkg::NUM_IN * PKTS || link_v != '0)
    begin
      @(negedge clk);
      drive_inputs();
      watch_timeout("all input packets to be accepted");
    end

    cycles = 0;
    while (queued != 0)
    begin
      @(negedge clk);
      drive_inputs();
      watch_timeout("the concentrated link to drain");
    end

    check_idle();
    check_count("body flits still owed on conc_data_o", out_left, 0);
    for (int n = 0; n < wormhole_pkg::NUM_IN; n++)
    begin
      check_count($sformatf("packets delivered from link %0d", n), delivered[n], PKTS);
    end
    // bound assertions count their own failures
    if (i_wormhole_concentrator_in.i_chk.fail_count == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tests/wormhole_concentrator_chk.sv
module wormhole_concentrator_chk
(
  input logic                                clk_i,
  input logic                                reset_i,
  input logic                                conc_v_i,
  input wormhole_pkg::flit_t                 conc_data_i,
  input logic                                conc_ready_i,
  input logic [wormhole_pkg::NUM_IN-1:0]     yumi_i
);

  // body flits still owed by the packet on the concentrated link
  wormhole_pkg::len_t              left_r;
  // pop vector of the header, the whole packet must come from there
  logic [wormhole_pkg::NUM_IN-1:0] owner_r;
  logic                            xfer;
  // number of failed assertions so far
  int                              fail_count = 0;

  assign xfer = conc_v_i & conc_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      left_r  <= '0;
      owner_r <= '0;
    end
    else if (xfer)
    begin
      if (left_r == '0)
      begin
        left_r  <= conc_data_i[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH];
        owner_r <= yumi_i;
      end
      else
      begin
        left_r <= left_r - wormhole_pkg::len_t'(1);
      end
    end
  end

  // link stays idle while reset is held
  a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !conc_v_i)
  else
  begin
    $error("concentrated valid high right after a reset edge");
    fail_count++;
  end

  // a presented flit that is not taken stays put
  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    conc_v_i && !conc_ready_i |=> conc_v_i && $stable(conc_data_i))
  else
  begin
    $error("stalled concentrated flit changed or vanished");
    fail_count++;
  end

  // body flits never come from another input
  a_no_interleave: assert property (@(posedge clk_i) disable iff (reset_i)
    xfer && left_r != '0 |-> yumi_i == owner_r)
  else
  begin
    $error("body flit popped from a different input than its header");
    fail_count++;
  end

endmodule

//--- tests/wormhole_clock_gen.sv
module wormhole_clock_gen
(
  output logic clk_o,
  output logic reset_o
);

  // 40 unit period, reset held for the first 8 rising edges
  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    // drop reset on a falling edge like every other input
    @(negedge clk_o);
    reset_o = 1'b0;
  end

  always #20 clk_o = ~clk_o;

endmodule

//--- src/wormhole_concentrator_in.sv
module wormhole_concentrator_in
(
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  // unconcentrated links
  input  logic                [wormhole_pkg::NUM_IN-1:0] link_v_i,
  input  wormhole_pkg::flit_t [wormhole_pkg::NUM_IN-1:0] link_data_i,
  output logic                [wormhole_pkg::NUM_IN-1:0] link_ready_o,

  // concentrated link
  output logic                                          conc_v_o,
  output wormhole_pkg::flit_t                           conc_data_o,
  input  logic                                          conc_ready_i
);

  // buffer heads from each input channel
  logic                [wormhole_pkg::NUM_IN-1:0] fifo_v;
  wormhole_pkg::flit_t [wormhole_pkg::NUM_IN-1:0] fifo_data;

  // header tracking from each input, pops back from the output
  logic [wormhole_pkg::NUM_IN-1:0] req;
  logic [wormhole_pkg::NUM_IN-1:0] releases;
  logic [wormhole_pkg::NUM_IN-1:0] yumi;

  // one buffer and tracker per link
  for (genvar n = 0; n < wormhole_pkg::NUM_IN; n++)
  begin : in_ch
    wormhole_in_channel i_in_channel
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .v_i         (link_v_i[n]),
      .data_i      (link_data_i[n]),
      .ready_o     (link_ready_o[n]),
      .fifo_v_o    (fifo_v[n]),
      .fifo_data_o (fifo_data[n]),
      .yumi_i      (yumi[n]),
      .req_o       (req[n]),
      .release_o   (releases[n])
    );
  end

  // packet granular round robin onto the concentrated link
  wormhole_output_control i_output_control
  (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req),
    .release_i (releases),
    .valid_i   (fifo_v),
    .data_i    (fifo_data),
    .yumi_o    (yumi),
    .ready_i   (conc_ready_i),
    .valid_o   (conc_v_o),
    .data_o    (conc_data_o)
  );

endmodule

//--- src/wormhole_output_control.sv
module wormhole_output_control
(
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  // per input tracking and buffer heads
  input  logic                [wormhole_pkg::NUM_IN-1:0] req_i,
  input  logic                [wormhole_pkg::NUM_IN-1:0] release_i,
  input  logic                [wormhole_pkg::NUM_IN-1:0] valid_i,
  input  wormhole_pkg::flit_t [wormhole_pkg::NUM_IN-1:0] data_i,
  output logic                [wormhole_pkg::NUM_IN-1:0] yumi_o,

  // concentrated link
  input  logic                                          ready_i,
  output logic                                          valid_o,
  output wormhole_pkg::flit_t                           data_o
);

  wormhole_pkg::out_state_e                state_r;
  logic [wormhole_pkg::NUM_IN-1:0]         grant_r;
  logic [$clog2(wormhole_pkg::NUM_IN)-1:0] ptr_r;
  logic [$clog2(wormhole_pkg::NUM_IN)-1:0] ptr_next;

  // combinational arbitration result
  logic [wormhole_pkg::NUM_IN-1:0] arb_grant;
  logic                            arb_found;

  // grant in use this cycle
  logic [wormhole_pkg::NUM_IN-1:0] sel;
  logic                            pop_release;

  // round robin: first requester at or after the pointer
  always_comb
  begin
    int idx;
    arb_grant = '0;
    arb_found = 1'b0;
    ptr_next  = ptr_r;
    for (int k = 0; k < wormhole_pkg::NUM_IN; k++)
    begin
      idx = (int'(ptr_r) + k) % wormhole_pkg::NUM_IN;
      if (!arb_found && req_i[idx])
      begin
        arb_found      = 1'b1;
        arb_grant[idx] = 1'b1;
        // pointer moves just past the winner
        ptr_next = ($clog2(wormhole_pkg::NUM_IN))'((idx + 1) % wormhole_pkg::NUM_IN);
      end
    end
  end

  // fresh pick while idle, held grant while a packet is in flight
  assign sel = (state_r == wormhole_pkg::OUT_HOLD) ? grant_r : arb_grant;

  // handshake towards the buffers and the concentrated link
  assign valid_o     = |(sel & valid_i);
  assign yumi_o      = sel & valid_i & {wormhole_pkg::NUM_IN{ready_i}};
  assign pop_release = |(yumi_o & release_i);

  // one hot and-or selector for the concentrated data
  always_comb
  begin
    data_o = '0;
    for (int k = 0; k < wormhole_pkg::NUM_IN; k++)
    begin
      data_o = data_o | (data_i[k] & {wormhole_pkg::FLIT_WIDTH{sel[k]}});
    end
  end

  // grant register, pointer and state
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= wormhole_pkg::OUT_ARB;
      grant_r <= '0;
      ptr_r   <= '0;
    end
    else
    begin
      case (state_r)
        wormhole_pkg::OUT_ARB:
        begin
          if (arb_found)
          begin
            grant_r <= arb_grant;
            ptr_r   <= ptr_next;
            // a single flit packet that leaves right away needs no hold,
            // otherwise lock the grant so a stalled head stays selected
            if (!pop_release)
            begin
              state_r <= wormhole_pkg::OUT_HOLD;
            end
          end
        end
        wormhole_pkg::OUT_HOLD:
        begin
          // last flit popped, arbitrate again next cycle
          if (pop_release)
          begin
            state_r <= wormhole_pkg::OUT_ARB;
            grant_r <= '0;
          end
        end
        default:
        begin
          state_r <= wormhole_pkg::OUT_ARB;
        end
      endcase
    end
  end

endmodule

//--- src/wormhole_in_channel.sv
module wormhole_in_channel
(
  input  logic                clk_i,
  input  logic                reset_i,

  // unconcentrated link, ready/valid
  input  logic                v_i,
  input  wormhole_pkg::flit_t data_i,
  output logic                ready_o,

  // buffer head towards the output controller
  output logic                fifo_v_o,
  output wormhole_pkg::flit_t fifo_data_o,
  input  logic                yumi_i,

  // packet tracking towards the output controller
  output logic                req_o,
  output logic                release_o
);

  // two entry circular buffer
  wormhole_pkg::flit_t mem_r [2];
  logic                wr_ptr_r;
  logic                rd_ptr_r;
  logic [1:0]          count_r;
  logic                push;

  // header tracker
  wormhole_pkg::in_state_e state_r;
  wormhole_pkg::len_t      body_cnt_r;
  wormhole_pkg::len_t      head_len;
  logic                    head_is_hdr;

  // accept whenever a slot is free, so back to back flits stream at full rate
  assign ready_o = ~count_r[1];
  assign push    = v_i & ready_o;

  // head is valid one cycle after the accepting edge
  assign fifo_v_o    = |count_r;
  assign fifo_data_o = mem_r[rd_ptr_r];

  // payload storage
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      // yumi is only raised while the head is valid
      if (yumi_i)
      begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      case ({push, yumi_i})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  // len field of the head, only meaningful when the head is a header
  assign head_len    = fifo_data_o[wormhole_pkg::LEN_LSB +: wormhole_pkg::LEN_WIDTH];
  assign head_is_hdr = (state_r == wormhole_pkg::IN_HEADER);

  // request the output only with a header waiting
  assign req_o = fifo_v_o & head_is_hdr;

  // final flit of a packet: zero length header, or last body flit
  assign release_o = fifo_v_o
                   & (head_is_hdr ? (head_len == '0)
                                  : (body_cnt_r == wormhole_pkg::len_t'(1)));

  // count the body flits of the current packet as they are popped
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= wormhole_pkg::IN_HEADER;
      body_cnt_r <= '0;
    end
    else if (yumi_i)
    begin
      case (state_r)
        wormhole_pkg::IN_HEADER:
        begin
          // a header without body keeps the tracker in IN_HEADER
          if (head_len != '0)
          begin
            state_r    <= wormhole_pkg::IN_BODY;
            body_cnt_r <= head_len;
          end
        end
        wormhole_pkg::IN_BODY:
        begin
          body_cnt_r <= body_cnt_r - 1'b1;
          // last body flit leaves, next head is a header again
          if (body_cnt_r == wormhole_pkg::len_t'(1))
          begin
            state_r <= wormhole_pkg::IN_HEADER;
          end
        end
        default:
        begin
          state_r <= wormhole_pkg::IN_HEADER;
        end
      endcase
    end
  end

endmodule

//--- src/wormhole_pkg.sv
package wormhole_pkg;

  // one flit is a single word on every link
  localparam int FLIT_WIDTH = 16;

  // header layout, low to high: cord, len, cid, then free payload bits
  localparam int CORD_WIDTH = 4;
  localparam int LEN_WIDTH  = 3;
  localparam int CID_WIDTH  = 2;

  // number of unconcentrated links merged onto the concentrated link
  localparam int NUM_IN = 4;

  // field positions inside a header flit
  localparam int LEN_LSB = CORD_WIDTH;
  localparam int CID_LSB = LEN_LSB + LEN_WIDTH;

  // flit and length field types
  typedef logic [FLIT_WIDTH-1:0] flit_t;
  typedef logic [LEN_WIDTH-1:0]  len_t;

  // input side packet tracker
  // IN_HEADER: next flit at the buffer head is a header
  // IN_BODY: body flits of the current packet remain
  typedef enum logic
  {
    IN_HEADER,
    IN_BODY
  } in_state_e;

  // concentrated output controller
  // OUT_ARB: no grant held, arbitrate among requesting inputs
  // OUT_HOLD: a packet is in flight on the granted input
  typedef enum logic
  {
    OUT_ARB,
    OUT_HOLD
  } out_state_e;

endpackage
